/* filelist.f */
source/rs_pkg.sv
source/rs_entry.sv
source/rs_alloc.sv
source/rs_select.sv
source/rs_top.sv
verif/rs_tb.sv

/* Makefile */
# Verilator build and run for the reservation station testbench

VERILATOR  ?= verilator
TOP        ?= rs_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
BIN        ?= V$(TOP)
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(BIN)

# the exit status is that of the search for the pass message
run: build
	@out="$$(./$(BUILD_DIR)/$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verif/rs_tb.sv */
// reservation station testbench
// directed and random dispatch/CDB traffic against an occupancy and
// wakeup model, checked by assertions on the DUT ports

`timescale 1ns/1ps
`default_nettype none

module rs_tb;

    localparam int unsigned N               = rs_pkg::RS_ENTRIES;
    localparam int unsigned ROBS            = 1 << rs_pkg::ROB_W;
    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 8;
    localparam int          DIRECTED_CYCLES = 200;   // generous bound for directed parts
    localparam int          RANDOM_CYCLES   = 2000;
    localparam int          DRAIN_LIMIT     = 200;
    localparam int          ISSUE_WAIT      = 20;
    localparam int          TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES
                                              + RANDOM_CYCLES + DRAIN_LIMIT;
    localparam int          WATCHDOG_MARGIN = 1000;  // ns
    localparam int unsigned SEED            = 32'h97e6_cca8;

    logic clk = 1'b0;
    logic reset;
    logic flush_i;
    logic disp_valid_i;
    logic [rs_pkg::ROB_W-1:0] disp_rob_idx_i;
    logic [rs_pkg::OPC_W-1:0] disp_opcode_i;
    logic [rs_pkg::FU_W-1:0]  disp_fu_type_i;
    logic [rs_pkg::IMM_W-1:0] disp_imm_i;
    logic [rs_pkg::TAG_W-1:0] disp_dest_tag_i;
    logic [rs_pkg::TAG_W-1:0] disp_src1_tag_i;
    logic                     disp_src1_ready_i;
    logic [rs_pkg::TAG_W-1:0] disp_src2_tag_i;
    logic                     disp_src2_ready_i;
    logic [rs_pkg::CDB_WIDTH-1:0]                   cdb_valid_i;
    logic [rs_pkg::CDB_WIDTH-1:0][rs_pkg::TAG_W-1:0] cdb_tag_i;
    logic                     rs_full_o;
    logic                     issue_valid_o;
    logic [rs_pkg::ROB_W-1:0] issue_rob_idx_o;
    logic [rs_pkg::OPC_W-1:0] issue_opcode_o;
    logic [rs_pkg::FU_W-1:0]  issue_fu_type_o;
    logic [rs_pkg::IMM_W-1:0] issue_imm_o;
    logic [rs_pkg::TAG_W-1:0] issue_dest_tag_o;
    logic [rs_pkg::TAG_W-1:0] issue_src1_tag_o;
    logic [rs_pkg::TAG_W-1:0] issue_src2_tag_o;

    // reference model, indexed by rob_idx
    logic                     m_live  [ROBS];
    logic [rs_pkg::OPC_W-1:0] m_opcode[ROBS];
    logic [rs_pkg::FU_W-1:0]  m_fu    [ROBS];
    logic [rs_pkg::IMM_W-1:0] m_imm   [ROBS];
    logic [rs_pkg::TAG_W-1:0] m_dest  [ROBS];
    logic [rs_pkg::TAG_W-1:0] m_src1  [ROBS];
    logic [rs_pkg::TAG_W-1:0] m_src2  [ROBS];
    logic                     m_woke1 [ROBS];
    logic                     m_woke2 [ROBS];
    int                       m_disp_cyc [ROBS];
    int                       m_ready_cyc[ROBS];  // cycle both sources were seen

    int live_count = 0;
    int cyc        = 0;
    int errors     = 0;
    int n_disp     = 0;
    int n_issued   = 0;
    logic [rs_pkg::ROB_W-1:0] next_rob = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    rs_top dut (.*);

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    // ========================================
    // stimulus helpers, called on a rising edge
    // ========================================
    task automatic idle_inputs();
        disp_valid_i <= 1'b0;
        cdb_valid_i  <= '0;
        flush_i      <= 1'b0;
    endtask

    task automatic put_on_cdb(input int lane, input logic [rs_pkg::TAG_W-1:0] tag);
        cdb_valid_i[lane] <= 1'b1;
        cdb_tag_i[lane]   <= tag;
    endtask

    task automatic drive_dispatch(input logic [rs_pkg::ROB_W-1:0] rob,
                                  input logic [rs_pkg::TAG_W-1:0] tag1,
                                  input logic                     rdy1,
                                  input logic [rs_pkg::TAG_W-1:0] tag2,
                                  input logic                     rdy2);
        disp_valid_i      <= 1'b1;
        disp_rob_idx_i    <= rob;
        disp_opcode_i     <= rs_pkg::OPC_W'($urandom);
        disp_fu_type_i    <= rs_pkg::FU_W'($urandom);
        disp_imm_i        <= rs_pkg::IMM_W'($urandom);
        disp_dest_tag_i   <= rs_pkg::TAG_W'($urandom);
        disp_src1_tag_i   <= tag1;
        disp_src1_ready_i <= rdy1;
        disp_src2_tag_i   <= tag2;
        disp_src2_ready_i <= rdy2;
    endtask

    // skip rob indices still waiting in the model
    task automatic next_free_rob(output logic [rs_pkg::ROB_W-1:0] rob);
        for (int k = 0; k < ROBS && m_live[next_rob]; k++)
            next_rob = next_rob + 1'b1;
        rob      = next_rob;
        next_rob = next_rob + 1'b1;
    endtask

    function automatic logic [rs_pkg::TAG_W-1:0] random_tag();
        return rs_pkg::TAG_W'($urandom_range(0, 7));  // small pool, frequent hits
    endfunction

    // counts negedges until issue_valid_o, 0 when none
    task automatic wait_for_issue(output int lat);
        lat = 0;
        for (int k = 1; k <= ISSUE_WAIT; k++) begin
            @(negedge clk);
            if (issue_valid_o) begin
                lat = k;
                break;
            end
        end
        if (lat == 0)
            flag_mismatch($sformatf("no instruction issued within %0d cycles", ISSUE_WAIT));
    endtask

    // ========================================
    // reference model, updated mid-cycle
    // ========================================
    task automatic clear_model();
        for (int r = 0; r < ROBS; r++)
            m_live[r] = 1'b0;
        live_count = 0;
    endtask

    task automatic retire_issue();
        logic [rs_pkg::ROB_W-1:0] r;
        r = issue_rob_idx_o;
        if (!issue_valid_o)
            return;
        assert (m_live[r])
            else flag_mismatch($sformatf("issued rob %0d which is not outstanding", r));
        if (m_live[r]) begin
            assert (issue_opcode_o == m_opcode[r] && issue_fu_type_o == m_fu[r]
                    && issue_imm_o == m_imm[r] && issue_dest_tag_o == m_dest[r]
                    && issue_src1_tag_o == m_src1[r] && issue_src2_tag_o == m_src2[r])
                else flag_mismatch($sformatf("rob %0d issued with wrong fields", r));
            assert (m_woke1[r] && m_woke2[r] && cyc > m_ready_cyc[r])
                else flag_mismatch($sformatf("rob %0d issued before its sources", r));
            assert (cyc >= m_disp_cyc[r] + 2)
                else flag_mismatch($sformatf("rob %0d issued too soon after dispatch", r));
            m_live[r] = 1'b0;
            live_count--;
            n_issued++;
        end
    endtask

    task automatic record_dispatch();
        logic [rs_pkg::ROB_W-1:0] r;
        r = disp_rob_idx_i;
        m_live[r]      = 1'b1;
        m_opcode[r]    = disp_opcode_i;
        m_fu[r]        = disp_fu_type_i;
        m_imm[r]       = disp_imm_i;
        m_dest[r]      = disp_dest_tag_i;
        m_src1[r]      = disp_src1_tag_i;
        m_src2[r]      = disp_src2_tag_i;
        m_woke1[r]     = disp_src1_ready_i;
        m_woke2[r]     = disp_src2_ready_i;
        m_disp_cyc[r]  = cyc;
        m_ready_cyc[r] = cyc;
        live_count++;
        n_disp++;
    endtask

    task automatic wake_from_cdb();
        for (int r = 0; r < ROBS; r++) begin
            if (m_live[r] && !(m_woke1[r] && m_woke2[r])) begin
                for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
                    if (cdb_valid_i[l] && cdb_tag_i[l] == m_src1[r])
                        m_woke1[r] = 1'b1;
                    if (cdb_valid_i[l] && cdb_tag_i[l] == m_src2[r])
                        m_woke2[r] = 1'b1;
                end
                if (m_woke1[r] && m_woke2[r])
                    m_ready_cyc[r] = cyc;
            end
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            clear_model();
        end else begin
            retire_issue();  // issue frees its slot before this cycle's dispatch
            assert (rs_full_o == (live_count == N))
                else flag_mismatch($sformatf("rs_full_o %0b with %0d outstanding",
                                             rs_full_o, live_count));
            if (disp_valid_i && !flush_i && live_count < N)
                record_dispatch();
            wake_from_cdb();
            if (flush_i)
                clear_model();
        end
    end

    assert property (@(posedge clk) disable iff (reset)
                     flush_i |=> !issue_valid_o && !rs_full_o)
        else flag_mismatch("issue or full seen in the cycle after a flush");

    assert property (@(posedge clk) disable iff (reset)
                     !issue_valid_o |-> (issue_rob_idx_o == '0 && issue_opcode_o == '0
                     && issue_fu_type_o == '0 && issue_imm_o == '0
                     && issue_dest_tag_o == '0 && issue_src1_tag_o == '0
                     && issue_src2_tag_o == '0))
        else flag_mismatch("issue fields not zero while issue_valid_o is low");

    // ========================================
    // test sequences
    // ========================================
    task automatic check_ready_latency();
        logic [rs_pkg::ROB_W-1:0] rob;
        int lat;
        @(posedge clk);
        next_free_rob(rob);
        drive_dispatch(rob, rs_pkg::TAG_W'(5), 1'b1, rs_pkg::TAG_W'(6), 1'b1);
        @(posedge clk);
        idle_inputs();
        wait_for_issue(lat);
        assert (lat == 2) else flag_mismatch($sformatf("ready issue after %0d cycles", lat));
    endtask

    task automatic check_wakeup();
        logic [rs_pkg::ROB_W-1:0] rob;
        int lat;
        @(posedge clk);
        next_free_rob(rob);
        drive_dispatch(rob, rs_pkg::TAG_W'(40), 1'b0, rs_pkg::TAG_W'(41), 1'b0);
        @(posedge clk);
        idle_inputs();
        repeat (3) @(posedge clk);
        put_on_cdb(0, rs_pkg::TAG_W'(40));
        @(posedge clk);
        idle_inputs();
        repeat (2) @(posedge clk);
        put_on_cdb(1, rs_pkg::TAG_W'(41));  // last source, on the other lane
        @(posedge clk);
        idle_inputs();
        wait_for_issue(lat);
        assert (lat == 1) else flag_mismatch($sformatf("wakeup issue after %0d cycles", lat));
        // tag broadcast in the dispatch cycle itself
        @(posedge clk);
        next_free_rob(rob);
        drive_dispatch(rob, rs_pkg::TAG_W'(50), 1'b0, rs_pkg::TAG_W'(51), 1'b1);
        put_on_cdb(1, rs_pkg::TAG_W'(50));
        @(posedge clk);
        idle_inputs();
        wait_for_issue(lat);
        assert (lat == 2) else flag_mismatch($sformatf("bypass issue after %0d cycles", lat));
    endtask

    task automatic run_random();
        logic [rs_pkg::ROB_W-1:0] rob;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            idle_inputs();
            if ($urandom_range(0, 99) < 45) begin
                next_free_rob(rob);
                drive_dispatch(rob, random_tag(), 1'($urandom_range(0, 99) < 60),
                               random_tag(), 1'($urandom_range(0, 99) < 60));
            end
            for (int l = 0; l < rs_pkg::CDB_WIDTH; l++) begin
                if ($urandom_range(0, 99) < 40)
                    put_on_cdb(l, random_tag());
            end
            if ($urandom_range(0, 99) == 0)
                flush_i <= 1'b1;  // rare, hits grants in flight
        end
    endtask

    task automatic drain_station();
        int k;
        k = 0;
        while (live_count > 0 && k < DRAIN_LIMIT) begin
            @(posedge clk);
            idle_inputs();
            put_on_cdb(0, rs_pkg::TAG_W'(2 * (k % 4)));      // sweep the tag pool
            put_on_cdb(1, rs_pkg::TAG_W'(2 * (k % 4) + 1));
            k++;
        end
        @(posedge clk);
        idle_inputs();
        repeat (3) @(posedge clk);
        assert (live_count == 0)
            else flag_mismatch($sformatf("%0d accepted instructions never issued", live_count));
    endtask

    task automatic check_full_and_flush();
        logic [rs_pkg::ROB_W-1:0] rob;
        int lat;
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            next_free_rob(rob);
            drive_dispatch(rob, rs_pkg::TAG_W'(100 + i), 1'b0, rs_pkg::TAG_W'(110), 1'b1);
        end
        @(posedge clk);
        next_free_rob(rob);  // dropped, must never issue
        drive_dispatch(rob, rs_pkg::TAG_W'(1), 1'b1, rs_pkg::TAG_W'(2), 1'b1);
        @(negedge clk);
        assert (rs_full_o) else flag_mismatch("station not full after four dispatches");
        @(posedge clk);
        idle_inputs();
        repeat (4) @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        idle_inputs();
        put_on_cdb(0, rs_pkg::TAG_W'(100));  // flushed work stays dead
        put_on_cdb(1, rs_pkg::TAG_W'(101));
        @(posedge clk);
        idle_inputs();
        put_on_cdb(0, rs_pkg::TAG_W'(102));
        put_on_cdb(1, rs_pkg::TAG_W'(103));
        @(posedge clk);
        idle_inputs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!rs_full_o && !issue_valid_o) else flag_mismatch("station busy after flush");
        @(posedge clk);
        next_free_rob(rob);
        drive_dispatch(rob, rs_pkg::TAG_W'(3), 1'b1, rs_pkg::TAG_W'(4), 1'b1);
        @(posedge clk);
        idle_inputs();
        wait_for_issue(lat);
        assert (lat == 2) else flag_mismatch($sformatf("post-flush issue after %0d cycles", lat));
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================
    initial begin
        void'($urandom(SEED));
        reset             = 1'b1;
        flush_i           = 1'b0;
        disp_valid_i      = 1'b0;
        disp_rob_idx_i    = '0;
        disp_opcode_i     = '0;
        disp_fu_type_i    = '0;
        disp_imm_i        = '0;
        disp_dest_tag_i   = '0;
        disp_src1_tag_i   = '0;
        disp_src1_ready_i = 1'b0;
        disp_src2_tag_i   = '0;
        disp_src2_ready_i = 1'b0;
        cdb_valid_i       = '0;
        cdb_tag_i         = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (!issue_valid_o && !rs_full_o)
                else flag_mismatch("issue or full active after reset");
        end
        check_ready_latency();
        check_wakeup();
        run_random();
        drain_station();
        check_full_and_flush();
        repeat (4) @(posedge clk);
        $display("summary: %0d dispatched, %0d issued, %0d errors", n_disp, n_issued, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("timeout: the run did not finish within %0d cycles", TOTAL_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* source/rs_top.sv */
// reservation station top level
// allocator, slots and issue select for a single issue port

`timescale 1ns/1ps
`default_nettype none

module rs_top (
    input  wire logic                                            clk,
    input  wire logic                                            reset,
    input  wire logic                                            flush_i,
    input  wire logic                                            disp_valid_i,
    input  wire logic [rs_pkg::ROB_W-1:0]                        disp_rob_idx_i,
    input  wire logic [rs_pkg::OPC_W-1:0]                        disp_opcode_i,
    input  wire logic [rs_pkg::FU_W-1:0]                         disp_fu_type_i,
    input  wire logic [rs_pkg::IMM_W-1:0]                        disp_imm_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                        disp_dest_tag_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                        disp_src1_tag_i,
    input  wire logic                                            disp_src1_ready_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                        disp_src2_tag_i,
    input  wire logic                                            disp_src2_ready_i,
    input  wire logic [rs_pkg::CDB_WIDTH-1:0]                    cdb_valid_i,
    input  wire logic [rs_pkg::CDB_WIDTH-1:0][rs_pkg::TAG_W-1:0] cdb_tag_i,
    output logic                                                 rs_full_o,
    output logic                                                 issue_valid_o,
    output logic      [rs_pkg::ROB_W-1:0]                        issue_rob_idx_o,
    output logic      [rs_pkg::OPC_W-1:0]                        issue_opcode_o,
    output logic      [rs_pkg::FU_W-1:0]                         issue_fu_type_o,
    output logic      [rs_pkg::IMM_W-1:0]                        issue_imm_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_dest_tag_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_src1_tag_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_src2_tag_o
);

    localparam int unsigned N = rs_pkg::RS_ENTRIES;

    logic                              disp_valid;   // no allocation while flushing
    logic [N-1:0]                      alloc_grant;
    logic [N-1:0]                      issue_grant;
    logic [N-1:0]                      busy;
    logic [N-1:0]                      ready;
    logic [N-1:0][rs_pkg::ROB_W-1:0]   slot_rob_idx;
    logic [N-1:0][rs_pkg::OPC_W-1:0]   slot_opcode;
    logic [N-1:0][rs_pkg::FU_W-1:0]    slot_fu_type;
    logic [N-1:0][rs_pkg::IMM_W-1:0]   slot_imm;
    logic [N-1:0][rs_pkg::TAG_W-1:0]   slot_dest_tag;
    logic [N-1:0][rs_pkg::TAG_W-1:0]   slot_src1_tag;
    logic [N-1:0][rs_pkg::TAG_W-1:0]   slot_src2_tag;

    assign disp_valid = disp_valid_i && !flush_i;

    rs_alloc u_alloc (
        .disp_valid_i (disp_valid),
        .busy_i       (busy),
        .alloc_o      (alloc_grant),
        .full_o       (rs_full_o)    // strobes while full are dropped
    );

    // ========================================
    // station slots
    // ========================================
    for (genvar g = 0; g < N; g++) begin : g_slot
        rs_entry u_entry (
            .clk               (clk),
            .reset             (reset),
            .flush_i           (flush_i),
            .alloc_i           (alloc_grant[g]),
            .disp_rob_idx_i    (disp_rob_idx_i),
            .disp_opcode_i     (disp_opcode_i),
            .disp_fu_type_i    (disp_fu_type_i),
            .disp_imm_i        (disp_imm_i),
            .disp_dest_tag_i   (disp_dest_tag_i),
            .disp_src1_tag_i   (disp_src1_tag_i),
            .disp_src1_ready_i (disp_src1_ready_i),
            .disp_src2_tag_i   (disp_src2_tag_i),
            .disp_src2_ready_i (disp_src2_ready_i),
            .cdb_valid_i       (cdb_valid_i),
            .cdb_tag_i         (cdb_tag_i),
            .issue_grant_i     (issue_grant[g]),
            .busy_o            (busy[g]),
            .ready_o           (ready[g]),
            .rob_idx_o         (slot_rob_idx[g]),
            .opcode_o          (slot_opcode[g]),
            .fu_type_o         (slot_fu_type[g]),
            .imm_o             (slot_imm[g]),
            .dest_tag_o        (slot_dest_tag[g]),
            .src1_tag_o        (slot_src1_tag[g]),
            .src2_tag_o        (slot_src2_tag[g])
        );
    end

    rs_select u_select (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .ready_i          (ready),
        .rob_idx_i        (slot_rob_idx),
        .opcode_i         (slot_opcode),
        .fu_type_i        (slot_fu_type),
        .imm_i            (slot_imm),
        .dest_tag_i       (slot_dest_tag),
        .src1_tag_i       (slot_src1_tag),
        .src2_tag_i       (slot_src2_tag),
        .grant_o          (issue_grant),
        .issue_valid_o    (issue_valid_o),
        .issue_rob_idx_o  (issue_rob_idx_o),
        .issue_opcode_o   (issue_opcode_o),
        .issue_fu_type_o  (issue_fu_type_o),
        .issue_imm_o      (issue_imm_o),
        .issue_dest_tag_o (issue_dest_tag_o),
        .issue_src1_tag_o (issue_src1_tag_o),
        .issue_src2_tag_o (issue_src2_tag_o)
    );

endmodule

`default_nettype wire

/* source/rs_select.sv */
// reservation station issue select
// grants the lowest-index ready slot and registers its fields
// onto the issue port, one instruction per cycle

`timescale 1ns/1ps
`default_nettype none

module rs_select (
    input  wire logic                                            clk,
    input  wire logic                                            reset,
    input  wire logic                                            flush_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0]                   ready_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::ROB_W-1:0] rob_idx_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::OPC_W-1:0] opcode_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::FU_W-1:0]  fu_type_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::IMM_W-1:0] imm_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::TAG_W-1:0] dest_tag_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::TAG_W-1:0] src1_tag_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0][rs_pkg::TAG_W-1:0] src2_tag_i,
    output logic      [rs_pkg::RS_ENTRIES-1:0]                   grant_o,
    output logic                                                 issue_valid_o,
    output logic      [rs_pkg::ROB_W-1:0]                        issue_rob_idx_o,
    output logic      [rs_pkg::OPC_W-1:0]                        issue_opcode_o,
    output logic      [rs_pkg::FU_W-1:0]                         issue_fu_type_o,
    output logic      [rs_pkg::IMM_W-1:0]                        issue_imm_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_dest_tag_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_src1_tag_o,
    output logic      [rs_pkg::TAG_W-1:0]                        issue_src2_tag_o
);

    logic                     any_ready;
    logic [rs_pkg::IDX_W-1:0] sel_idx;
    logic                     do_issue;

    // lowest ready index
    always_comb begin
        any_ready = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
            if (!any_ready && ready_i[i]) begin
                any_ready = 1'b1;
                sel_idx   = rs_pkg::IDX_W'(i);
            end
        end
    end

    assign do_issue = any_ready && !flush_i;  // flush discards the grant

    always_comb begin
        grant_o = '0;
        if (do_issue)
            grant_o[sel_idx] = 1'b1;
    end

    // ========================================
    // issue register
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid_o    <= 1'b0;
            issue_rob_idx_o  <= '0;
            issue_opcode_o   <= '0;
            issue_fu_type_o  <= '0;
            issue_imm_o      <= '0;
            issue_dest_tag_o <= '0;
            issue_src1_tag_o <= '0;
            issue_src2_tag_o <= '0;
        end else if (do_issue) begin
            issue_valid_o    <= 1'b1;
            issue_rob_idx_o  <= rob_idx_i[sel_idx];
            issue_opcode_o   <= opcode_i[sel_idx];
            issue_fu_type_o  <= fu_type_i[sel_idx];
            issue_imm_o      <= imm_i[sel_idx];
            issue_dest_tag_o <= dest_tag_i[sel_idx];
            issue_src1_tag_o <= src1_tag_i[sel_idx];
            issue_src2_tag_o <= src2_tag_i[sel_idx];
        end else begin
            // idle or flushed, fields read zero
            issue_valid_o    <= 1'b0;
            issue_rob_idx_o  <= '0;
            issue_opcode_o   <= '0;
            issue_fu_type_o  <= '0;
            issue_imm_o      <= '0;
            issue_dest_tag_o <= '0;
            issue_src1_tag_o <= '0;
            issue_src2_tag_o <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/rs_alloc.sv */
// reservation station allocator
// steers a dispatch into the lowest free slot and flags a full station

`timescale 1ns/1ps
`default_nettype none

module rs_alloc (
    input  wire logic                           disp_valid_i,
    input  wire logic [rs_pkg::RS_ENTRIES-1:0]  busy_i,
    output logic      [rs_pkg::RS_ENTRIES-1:0]  alloc_o,
    output logic                                full_o
);

    logic [rs_pkg::RS_ENTRIES-1:0] free;
    logic                          found;

    assign free   = ~busy_i;
    assign full_o = &busy_i;  // no free slot left

    // priority encoder, lowest free index wins
    always_comb begin
        alloc_o = '0;
        found   = 1'b0;
        for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
            if (!found && free[i]) begin
                found      = 1'b1;
                alloc_o[i] = disp_valid_i;  // nothing when no dispatch
            end
        end
    end

endmodule

`default_nettype wire

/* source/rs_entry.sv */
// reservation station slot
// holds one waiting instruction, wakes its sources from the CDB
// in the same cycle and frees itself when granted for issue

`timescale 1ns/1ps
`default_nettype none

module rs_entry (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic                                          flush_i,
    input  wire logic                                          alloc_i,
    input  wire logic [rs_pkg::ROB_W-1:0]                      disp_rob_idx_i,
    input  wire logic [rs_pkg::OPC_W-1:0]                      disp_opcode_i,
    input  wire logic [rs_pkg::FU_W-1:0]                       disp_fu_type_i,
    input  wire logic [rs_pkg::IMM_W-1:0]                      disp_imm_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                      disp_dest_tag_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                      disp_src1_tag_i,
    input  wire logic                                          disp_src1_ready_i,
    input  wire logic [rs_pkg::TAG_W-1:0]                      disp_src2_tag_i,
    input  wire logic                                          disp_src2_ready_i,
    input  wire logic [rs_pkg::CDB_WIDTH-1:0]                  cdb_valid_i,
    input  wire logic [rs_pkg::CDB_WIDTH-1:0][rs_pkg::TAG_W-1:0] cdb_tag_i,
    input  wire logic                                          issue_grant_i,
    output logic                                               busy_o,
    output logic                                               ready_o,
    output logic [rs_pkg::ROB_W-1:0]                           rob_idx_o,
    output logic [rs_pkg::OPC_W-1:0]                           opcode_o,
    output logic [rs_pkg::FU_W-1:0]                            fu_type_o,
    output logic [rs_pkg::IMM_W-1:0]                           imm_o,
    output logic [rs_pkg::TAG_W-1:0]                           dest_tag_o,
    output logic [rs_pkg::TAG_W-1:0]                           src1_tag_o,
    output logic [rs_pkg::TAG_W-1:0]                           src2_tag_o
);

    logic busy;
    logic src1_rdy, src2_rdy;   // sticky ready flags
    logic src1_hit, src2_hit;   // stored tags seen on the CDB this cycle
    logic disp1_hit, disp2_hit; // incoming tags seen on the CDB this cycle

    // any valid lane carrying this tag
    function automatic logic cdb_match(input logic [rs_pkg::TAG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < rs_pkg::CDB_WIDTH; k++) begin
            if (cdb_valid_i[k] && (cdb_tag_i[k] == tag))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // ========================================
    // wakeup
    // ========================================
    always_comb begin
        src1_hit  = cdb_match(src1_tag_o);
        src2_hit  = cdb_match(src2_tag_o);
        disp1_hit = cdb_match(disp_src1_tag_i);  // tag produced during dispatch
        disp2_hit = cdb_match(disp_src2_tag_i);
    end

    // bypass so a hit this cycle can be selected right away
    assign ready_o = busy && (src1_rdy || src1_hit) && (src2_rdy || src2_hit);
    assign busy_o  = busy;

    // ========================================
    // slot state
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (flush_i) begin
            busy     <= 1'b0;
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (alloc_i) begin
            // allocator only picks a free slot
            busy     <= 1'b1;
            src1_rdy <= disp_src1_ready_i || disp1_hit;
            src2_rdy <= disp_src2_ready_i || disp2_hit;
        end else if (issue_grant_i) begin
            busy     <= 1'b0;  // free in the issue cycle
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (busy) begin
            src1_rdy <= src1_rdy || src1_hit;
            src2_rdy <= src2_rdy || src2_hit;
        end
    end

    // instruction payload loaded on allocation
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rob_idx_o  <= disp_rob_idx_i;
            opcode_o   <= disp_opcode_i;
            fu_type_o  <= disp_fu_type_i;
            imm_o      <= disp_imm_i;
            dest_tag_o <= disp_dest_tag_i;
            src1_tag_o <= disp_src1_tag_i;
            src2_tag_o <= disp_src2_tag_i;
        end
    end

endmodule

`default_nettype wire

/* source/rs_pkg.sv */
// reservation station shared definitions
// widths and sizes used by the RTL and the testbench

`default_nettype none

package rs_pkg;

    // ========================================
    // register file and broadcast bus
    // ========================================
    localparam int unsigned PHYS_REGS = 128;
    localparam int unsigned TAG_W     = $clog2(PHYS_REGS);  // 7 bits
    localparam int unsigned CDB_WIDTH = 2;                  // broadcast lanes

    // ========================================
    // station sizing
    // ========================================
    localparam int unsigned RS_ENTRIES = 4;
    localparam int unsigned IDX_W      = $clog2(RS_ENTRIES);

    // ========================================
    // instruction fields
    // ========================================
    // carried through untouched, only the tags are looked at
    localparam int unsigned ROB_W = 5;   // reorder buffer index
    localparam int unsigned OPC_W = 4;   // opcode
    localparam int unsigned FU_W  = 2;   // functional unit type
    localparam int unsigned IMM_W = 16;  // immediate

endpackage

`default_nettype wire
